//--- test/ifu_input.txt
// records of 7 hex words: 1 addr data err 0 0 0 (memory word)
// 2 kind excsel cause operand stall pmp (event) | 3 pc instr comp illegal err err2 (expect)
00000001 00001080 00A00093 0 0 0 0
00000001 00001084 05134505 0 0 0 0
00000001 00001088 00000010 0 0 0 0
00000001 0000108C 80824581 0 0 0 0
00000001 00001090 00000013 0 0 0 0
00000001 00002000 4685FFFF 0 0 0 0
00000001 00002004 00200693 0 0 0 0
00000001 00002008 00300713 1 0 0 0
00000001 0000200C 07934789 0 0 0 0
00000001 00002010 45050040 1 0 0 0
00000001 00003000 30200073 0 0 0 0
00000001 0000301C 00004515 0 0 0 0
00000001 00004004 80820001 0 0 0 0
00000001 00005000 7B200073 0 0 0 0
00000001 1A110800 0FF0000F 0 0 0 0
00000001 1A110808 00100073 0 0 0 0
00000001 00006000 08130001 0 0 0 0
00000001 00006004 48010050 0 0 0 0
00000001 00007000 00000013 0 0 0 0
// boot, mixed widths with a spanning instruction and an illegal parcel
00000002 0 0 0 00001000 0 0
00000003 00001080 00A00093 0 0 0 0
00000003 00001084 00004505 1 0 0 0
00000003 00001086 00100513 0 0 0 0
00000003 0000108A 00000000 1 1 0 0
00000003 0000108C 00004581 1 0 0 0
00000003 0000108E 00008082 1 0 0 0
00000003 00001090 00000013 0 0 0 0
// jump to a halfword, bus errors, error in the second word only
00000002 1 0 0 00002002 28 0
00000003 00002002 00004685 1 0 0 0
00000003 00002004 00200693 0 0 0 0
00000003 00002008 00300713 0 0 1 0
00000003 0000200C 00004789 1 0 0 0
00000003 0000200E 00400793 0 0 0 1
00000003 00002012 00004505 1 0 1 0
// mispredict, then trap targets
00000002 5 0 0 0000108C 0 0
00000003 0000108C 00004581 1 0 0 0
00000003 0000108E 00008082 1 0 0 0
00000003 00001090 00000013 0 0 0 0
00000002 2 0 0 00003001 0 0
00000003 00003000 30200073 0 0 0 0
00000002 2 1 27 00003001 0 0
00000003 0000301C 00004515 1 0 0 0
00000003 0000301E 00000000 1 1 0 0
00000002 3 0 0 00004006 0 0
00000003 00004006 00008082 1 0 0 0
00000002 4 0 0 00005000 0 0
00000003 00005000 7B200073 0 0 0 0
00000002 2 2 0 00000000 0 0
00000003 1A110800 0FF0000F 0 0 0 0
00000002 2 3 0 00000000 0 0
00000003 1A110808 00100073 0 0 0 0
// pmp on the second half, then on the first
00000002 1 0 0 00006002 0 2
00000003 00006002 00500813 0 0 1 1
00000003 00006006 00004801 1 0 0 0
00000002 1 0 0 00007000 0 1
00000003 00007000 00000013 0 0 1 0
// heavy back-pressure over the boot stream
00000002 1 0 0 00001080 46 0
00000003 00001080 00A00093 0 0 0 0
00000003 00001084 00004505 1 0 0 0
00000003 00001086 00100513 0 0 0 0
00000003 0000108A 00000000 1 1 0 0
00000003 0000108C 00004581 1 0 0 0
00000003 0000108E 00008082 1 0 0 0
00000003 00001090 00000013 0 0 0 0

//--- ifu.f
hw/ifu_pkg.sv
hw/ifu_pc_sel.sv
hw/ifu_fetch.sv
hw/ifu_align.sv
hw/ifu_id_reg.sv
hw/ifu_top.sv
test/tb_ifu.sv

//--- Bender.yml
package:
  name: ifu

sources:
  - hw/ifu_pkg.sv
  - hw/ifu_pc_sel.sv
  - hw/ifu_fetch.sv
  - hw/ifu_align.sv
  - hw/ifu_id_reg.sv
  - hw/ifu_top.sv
  - target: test
    files:
      - test/tb_ifu.sv

//--- test/tb_ifu.sv
`timescale 1ns/1ns

module tb_ifu;

  localparam int unsigned rec_w          = 7;   // words per record in the input file
  localparam int unsigned max_rec        = 96;
  localparam int unsigned timeout_cycles = 400; // per instruction of a stream

  logic                       clk_i;
  logic                       rst_ni;
  logic [ifu_pkg::addr_w-1:0] boot_addr_i;
  logic                       req_i;
  logic                       instr_req_o;
  logic [ifu_pkg::addr_w-1:0] instr_addr_o;
  logic                       instr_gnt_i;
  logic                       instr_rvalid_i;
  logic [ifu_pkg::addr_w-1:0] instr_rdata_i;
  logic                       instr_bus_err_i;
  logic                       instr_valid_clear_i;
  logic                       pc_set_i;
  ifu_pkg::pc_sel_e           pc_mux_i;
  logic                       nt_branch_mispredict_i;
  logic [ifu_pkg::addr_w-1:0] nt_branch_addr_i;
  ifu_pkg::exc_pc_sel_e       exc_pc_mux_i;
  ifu_pkg::exc_cause_t        exc_cause_i;
  logic [ifu_pkg::addr_w-1:0] branch_target_ex_i;
  logic [ifu_pkg::addr_w-1:0] csr_mepc_i;
  logic [ifu_pkg::addr_w-1:0] csr_depc_i;
  logic [ifu_pkg::addr_w-1:0] csr_mtvec_i;
  logic                       csr_mtvec_init_o;
  logic                       pmp_err_if_i;
  logic                       pmp_err_if_plus2_i;
  logic                       id_in_ready_i;
  logic                       if_busy_o;
  logic                       instr_valid_id_o;
  logic                       instr_new_id_o;
  ifu_pkg::if_instr_t         instr_id_o;
  logic [ifu_pkg::addr_w-1:0] pc_if_o;
  logic [ifu_pkg::addr_w-1:0] pc_id_o;

  logic [31:0]        rec [max_rec*rec_w]; // raw input file
  logic [32:0]        mem [logic [31:0]];  // {err, data} per word address
  ifu_pkg::if_instr_t exp_q [$];           // stream expected after one event
  int unsigned        stall_pct;           // percent of cycles with id not ready
  int unsigned        checks;
  int unsigned        value_errors;
  int unsigned        other_errors;
  bit                 timed_out;
  bit                 hold_armed;          // valid must still be up this edge
  logic [31:0]        pc_if_xfer;          // if pc as it stood at the last edge

  ifu_top i_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_instr(input string name, input ifu_pkg::if_instr_t got,
                             input ifu_pkg::if_instr_t exp);
    checks++;
    if (got !== exp) begin
      value_errors++;
      $display("Fail %0t %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      value_errors++;
      $display("Fail %0t %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      value_errors++;
      $display("Fail %0t %s: got %b, expected %b", $time, name, got, exp);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // memory model, one request in flight
  //////////////////////////////////////////////////////////////////////

  function automatic logic [32:0] read_word(input logic [31:0] addr);
    if (mem.exists(addr)) begin
      return mem[addr];
    end
    return {1'b0, addr ^ 32'h5A5A_A5A5 ^ {addr[15:0], addr[31:16]}}; // unmapped fill
  endfunction

  int unsigned gnt_wait;
  int unsigned rsp_wait;
  bit          rsp_pend;
  logic [31:0] rsp_addr;
  logic [32:0] rsp_word;

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      instr_gnt_i    <= 1'b0;
      instr_rvalid_i <= 1'b0;
      rsp_pend = 1'b0;
      gnt_wait = 0;
    end else begin
      instr_rvalid_i <= 1'b0;
      if (instr_gnt_i) begin // grant taken at this edge
        instr_gnt_i <= 1'b0;
        rsp_pend = 1'b1;
        rsp_addr = instr_addr_o;
        rsp_wait = $urandom % 3;
      end else if (instr_req_o) begin
        if (gnt_wait == 0) begin
          instr_gnt_i <= 1'b1;
          gnt_wait = $urandom % 3;
        end else begin
          gnt_wait--;
        end
      end
      if (rsp_pend) begin
        if (rsp_wait == 0) begin
          rsp_word = read_word(rsp_addr);
          instr_rvalid_i  <= 1'b1;
          instr_rdata_i   <= rsp_word[31:0];
          instr_bus_err_i <= rsp_word[32];
          rsp_pend = 1'b0;
        end else begin
          rsp_wait--;
        end
      end
    end
  end

  // id side, random stalls and clears
  always @(posedge clk_i) begin
    id_in_ready_i       <= ($urandom % 100) >= stall_pct;
    instr_valid_clear_i <= ($urandom % 4) == 0;
  end

  // pc of the instruction handed over at this edge
  always @(posedge clk_i) begin
    pc_if_xfer <= pc_if_o;
  end

  // valid is only dropped by a clear
  always @(posedge clk_i) begin
    if (rst_ni && hold_armed) begin
      check_flag("instr_valid_id_o", instr_valid_id_o, 1'b1);
    end
    hold_armed = rst_ni && instr_valid_id_o && !instr_valid_clear_i;
  end

  //////////////////////////////////////////////////////////////////////
  // events and streams
  //////////////////////////////////////////////////////////////////////

  function automatic ifu_pkg::if_instr_t make_exp(input int unsigned r);
    ifu_pkg::if_instr_t e;
    int unsigned        b;
    b = r * rec_w;
    e.is_compressed   = rec[b+3][0];
    e.instr           = rec[b+2]; // rvc already zero extended in the file
    e.instr_c         = rec[b+2][15:0]; // first parcel either way
    e.illegal_c       = rec[b+4][0];
    e.fetch_err       = rec[b+5][0];
    e.fetch_err_plus2 = rec[b+6][0];
    e.pc              = rec[b+1];
    return e;
  endfunction

  task automatic apply_event(input int unsigned r);
    int unsigned b;
    b = r * rec_w;
    @(posedge clk_i);
    req_i              <= 1'b1;
    stall_pct          <= rec[b+5];
    pmp_err_if_i       <= rec[b+6][0];
    pmp_err_if_plus2_i <= rec[b+6][1];
    case (rec[b+1])
      0: begin
        pc_set_i    <= 1'b1;
        pc_mux_i    <= ifu_pkg::pc_boot;
        boot_addr_i <= rec[b+4];
      end
      1: begin
        pc_set_i           <= 1'b1;
        pc_mux_i           <= ifu_pkg::pc_jump;
        branch_target_ex_i <= rec[b+4];
      end
      2: begin
        pc_set_i     <= 1'b1;
        pc_mux_i     <= ifu_pkg::pc_exc;
        exc_pc_mux_i <= ifu_pkg::exc_pc_sel_e'(rec[b+2][1:0]);
        exc_cause_i  <= rec[b+3][5:0];
        csr_mtvec_i  <= rec[b+4];
      end
      3: begin
        pc_set_i   <= 1'b1;
        pc_mux_i   <= ifu_pkg::pc_mret;
        csr_mepc_i <= rec[b+4];
      end
      4: begin
        pc_set_i   <= 1'b1;
        pc_mux_i   <= ifu_pkg::pc_dret;
        csr_depc_i <= rec[b+4];
      end
      default: begin // not-taken mispredict
        nt_branch_mispredict_i <= 1'b1;
        nt_branch_addr_i       <= rec[b+4];
      end
    endcase
    @(posedge clk_i);
    check_flag("csr_mtvec_init_o", csr_mtvec_init_o, rec[b+1] == 0);
    pc_set_i               <= 1'b0;
    nt_branch_mispredict_i <= 1'b0;
  endtask

  // pulses before the squash belong to the old stream and were skipped
  task automatic receive_stream();
    int unsigned waited;
    int unsigned idx;
    waited = 0;
    idx    = 0;
    while (idx < exp_q.size() && !timed_out) begin
      @(posedge clk_i);
      waited++;
      if (instr_new_id_o) begin
        check_flag("instr_valid_id_o", instr_valid_id_o, 1'b1);
        check_instr("instr_id_o", instr_id_o, exp_q[idx]);
        check_addr("pc_id_o", pc_id_o, exp_q[idx].pc);
        check_addr("pc_if_o", pc_if_xfer, exp_q[idx].pc);
        idx++;
        waited = 0;
      end else if (waited > timeout_cycles) begin
        $display("Timeout: instruction at pc %h never reached the ID stage", exp_q[idx].pc);
        other_errors++;
        timed_out = 1'b1;
      end
    end
  endtask

  int unsigned r;

  initial begin
    rst_ni                 = 1'b0;
    boot_addr_i            = '0;
    req_i                  = 1'b0;
    instr_gnt_i            = 1'b0;
    instr_rvalid_i         = 1'b0;
    instr_rdata_i          = '0;
    instr_bus_err_i        = 1'b0;
    instr_valid_clear_i    = 1'b0;
    pc_set_i               = 1'b0;
    pc_mux_i               = ifu_pkg::pc_boot;
    nt_branch_mispredict_i = 1'b0;
    nt_branch_addr_i       = '0;
    exc_pc_mux_i           = ifu_pkg::exc_pc_base;
    exc_cause_i            = '0;
    branch_target_ex_i     = '0;
    csr_mepc_i             = '0;
    csr_depc_i             = '0;
    csr_mtvec_i            = '0;
    pmp_err_if_i           = 1'b0;
    pmp_err_if_plus2_i     = 1'b0;
    id_in_ready_i          = 1'b1;
    stall_pct              = 0;
    checks                 = 0;
    value_errors           = 0;
    other_errors           = 0;
    timed_out              = 1'b0;
    hold_armed             = 1'b0;
    void'($urandom(14135));

    for (int unsigned i = 0; i < max_rec * rec_w; i++) begin
      rec[i] = '0; // type 0 ends the file
    end
    $readmemh("test/ifu_input.txt", rec);
    if (rec[0] == 0) begin
      $display("Input file is missing or holds no records");
      other_errors++;
    end
    for (int unsigned i = 0; i < max_rec; i++) begin
      if (rec[i*rec_w] == 1) begin
        mem[rec[i*rec_w+1]] = {rec[i*rec_w+3][0], rec[i*rec_w+2]};
      end
    end

    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    check_flag("instr_req_o", instr_req_o, 1'b0); // quiet until boot
    check_flag("if_busy_o", if_busy_o, 1'b0);
    check_flag("instr_valid_id_o", instr_valid_id_o, 1'b0);
    check_flag("instr_new_id_o", instr_new_id_o, 1'b0);
    check_flag("csr_mtvec_init_o", csr_mtvec_init_o, 1'b0);

    r = 0;
    while (r < max_rec && rec[r*rec_w] != 0 && !timed_out) begin
      case (rec[r*rec_w])
        1: r++;
        2: begin
          apply_event(r);
          r++;
          exp_q.delete();
          while (r < max_rec && rec[r*rec_w] == 3) begin
            exp_q.push_back(make_exp(r));
            r++;
          end
          receive_stream();
        end
        default: begin
          $display("Input file record %0d has an unknown type", r);
          other_errors++;
          r = max_rec;
        end
      endcase
    end

    $display("checks %0d, value errors %0d, other errors %0d",
             checks, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- hw/ifu_top.sv
`timescale 1ns/1ns

module ifu_top (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic [ifu_pkg::addr_w-1:0] boot_addr_i,
  input  logic                       req_i,
  // instruction bus
  output logic                       instr_req_o,
  output logic [ifu_pkg::addr_w-1:0] instr_addr_o,
  input  logic                       instr_gnt_i,
  input  logic                       instr_rvalid_i,
  input  logic [ifu_pkg::addr_w-1:0] instr_rdata_i,
  input  logic                       instr_bus_err_i,
  // control from id/ex
  input  logic                       instr_valid_clear_i,
  input  logic                       pc_set_i,
  input  ifu_pkg::pc_sel_e           pc_mux_i,
  input  logic                       nt_branch_mispredict_i,
  input  logic [ifu_pkg::addr_w-1:0] nt_branch_addr_i,
  input  ifu_pkg::exc_pc_sel_e       exc_pc_mux_i,
  input  ifu_pkg::exc_cause_t        exc_cause_i,
  input  logic [ifu_pkg::addr_w-1:0] branch_target_ex_i,
  // csrs
  input  logic [ifu_pkg::addr_w-1:0] csr_mepc_i,
  input  logic [ifu_pkg::addr_w-1:0] csr_depc_i,
  input  logic [ifu_pkg::addr_w-1:0] csr_mtvec_i,
  output logic                       csr_mtvec_init_o,
  input  logic                       pmp_err_if_i,
  input  logic                       pmp_err_if_plus2_i,
  // id side
  input  logic                       id_in_ready_i,
  output logic                       if_busy_o,
  output logic                       instr_valid_id_o,
  output logic                       instr_new_id_o,
  output ifu_pkg::if_instr_t         instr_id_o,
  output logic [ifu_pkg::addr_w-1:0] pc_if_o,
  output logic [ifu_pkg::addr_w-1:0] pc_id_o
);

  ifu_pkg::redirect_t  redirect;
  ifu_pkg::fetch_rsp_t rsp;
  ifu_pkg::if_instr_t  if_instr;
  logic                rsp_valid;
  logic                slot_free;
  logic                fetch_busy;
  logic                if_instr_valid;

  ifu_pc_sel i_pc_sel (
    .pc_set_i, .pc_mux_i, .exc_pc_mux_i, .exc_cause_i, .boot_addr_i, .branch_target_ex_i,
    .csr_mepc_i, .csr_depc_i, .csr_mtvec_i, .nt_branch_mispredict_i, .nt_branch_addr_i,
    .redirect_o (redirect),
    .csr_mtvec_init_o
  );

  ifu_fetch i_fetch (
    .clk_i, .rst_ni, .req_i,
    .redirect_i  (redirect),
    .slot_free_i (slot_free),
    .instr_req_o, .instr_addr_o, .instr_gnt_i, .instr_rvalid_i, .instr_rdata_i, .instr_bus_err_i,
    .rsp_valid_o (rsp_valid),
    .rsp_o       (rsp),
    .busy_o      (fetch_busy)
  );

  ifu_align i_align (
    .clk_i, .rst_ni,
    .redirect_i    (redirect),
    .rsp_valid_i   (rsp_valid),
    .rsp_i         (rsp),
    .slot_free_o   (slot_free),
    .pmp_err_if_i, .pmp_err_if_plus2_i,
    .id_ready_i    (id_in_ready_i),
    .instr_valid_o (if_instr_valid),
    .instr_o       (if_instr),
    .pc_if_o
  );

  ifu_id_reg i_id_reg (
    .clk_i, .rst_ni,
    .instr_valid_i (if_instr_valid),
    .instr_i       (if_instr),
    .id_in_ready_i, .pc_set_i, .instr_valid_clear_i,
    .instr_valid_id_o, .instr_new_id_o, .instr_id_o
  );

  assign if_busy_o = fetch_busy | ~slot_free; // word in flight or still held
  assign pc_id_o   = instr_id_o.pc;

endmodule

//--- hw/ifu_id_reg.sv
`timescale 1ns/1ns

module ifu_id_reg (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               instr_valid_i,
  input  ifu_pkg::if_instr_t instr_i,
  input  logic               id_in_ready_i,
  input  logic               pc_set_i,
  input  logic               instr_valid_clear_i,
  output logic               instr_valid_id_o,
  output logic               instr_new_id_o,
  output ifu_pkg::if_instr_t instr_id_o
);

  logic xfer;    // valid and ready at this edge
  logic valid_d;
  logic valid_q;
  logic new_q;

  assign xfer = instr_valid_i & id_in_ready_i;

  //////////////////////////////////////////////////////////////////////
  // flags
  //////////////////////////////////////////////////////////////////////

  // set by a transfer unless squashed, then held until id clears it
  assign valid_d = (xfer & ~pc_set_i) | (valid_q & ~instr_valid_clear_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      new_q   <= 1'b0;
    end else begin
      valid_q <= valid_d;
      new_q   <= xfer; // one pulse per transfer
    end
  end

  //////////////////////////////////////////////////////////////////////
  // payload
  //////////////////////////////////////////////////////////////////////

  // frozen while id stalls
  always_ff @(posedge clk_i) begin
    if (xfer) begin
      instr_id_o <= instr_i;
    end
  end

  assign instr_valid_id_o = valid_q;
  assign instr_new_id_o   = new_q;

endmodule

//--- hw/ifu_align.sv
`timescale 1ns/1ns

module ifu_align (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  ifu_pkg::redirect_t         redirect_i,
  input  logic                       rsp_valid_i,
  input  ifu_pkg::fetch_rsp_t        rsp_i,
  output logic                       slot_free_o,
  input  logic                       pmp_err_if_i,
  input  logic                       pmp_err_if_plus2_i,
  input  logic                       id_ready_i,
  output logic                       instr_valid_o,
  output ifu_pkg::if_instr_t         instr_o,
  output logic [ifu_pkg::addr_w-1:0] pc_if_o
);

  ifu_pkg::fetch_rsp_t        slot_q;  // current word
  ifu_pkg::fetch_rsp_t        part_q;  // word whose upper parcel starts a spanning instr
  logic                       slot_vld_q;
  logic                       part_vld_q;
  logic                       off_q;   // 1: next instr starts in upper parcel
  logic [ifu_pkg::half_w-1:0] first_half;
  logic                       is_c;
  logic                       split;
  logic                       fire;
  logic                       first_err;
  logic                       second_err;
  logic                       pmp_plus2;
  logic [ifu_pkg::addr_w-1:0] pc;

  //////////////////////////////////////////////////////////////////////
  // parcel select
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    if (part_vld_q) begin
      first_half = part_q.data.half.hi;
      pc         = {part_q.addr[ifu_pkg::addr_w-1:2], 2'b10};
    end else begin
      first_half = off_q ? slot_q.data.half.hi : slot_q.data.half.lo;
      pc         = {slot_q.addr[ifu_pkg::addr_w-1:2], off_q, 1'b0};
    end
  end

  assign is_c  = (first_half[1:0] != 2'b11); // rvc unless low bits 11
  // uncompressed in the upper parcel, park it and fetch the next word
  assign split = slot_vld_q & ~part_vld_q & off_q & ~is_c;

  assign instr_valid_o = slot_vld_q & ~split & ~redirect_i.valid; // squash on redirect
  assign fire          = instr_valid_o & id_ready_i;

  //////////////////////////////////////////////////////////////////////
  // error merge
  //////////////////////////////////////////////////////////////////////

  assign first_err  = part_vld_q ? part_q.err : slot_q.err;
  assign second_err = part_vld_q & slot_q.err & ~part_q.err; // second word only
  assign pmp_plus2  = pc[1] & ~is_c & pmp_err_if_plus2_i;

  assign instr_o.instr           = is_c ? {{ifu_pkg::half_w{1'b0}}, first_half}
                                        : (part_vld_q ? {slot_q.data.half.lo, first_half}
                                                      : slot_q.data.word);
  assign instr_o.instr_c         = first_half;
  assign instr_o.is_compressed   = is_c;
  assign instr_o.illegal_c       = is_c & (first_half == '0); // only the zero parcel
  assign instr_o.fetch_err       = first_err | pmp_err_if_i | pmp_plus2;
  assign instr_o.fetch_err_plus2 = (pmp_plus2 | second_err) & ~pmp_err_if_i;
  assign instr_o.pc              = pc;

  assign pc_if_o     = pc;
  assign slot_free_o = ~slot_vld_q;

  //////////////////////////////////////////////////////////////////////
  // slot state
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      slot_vld_q <= 1'b0;
      part_vld_q <= 1'b0;
      off_q      <= 1'b0;
    end else if (redirect_i.valid) begin
      slot_vld_q <= 1'b0;
      part_vld_q <= 1'b0;
      off_q      <= redirect_i.target[1];
    end else if (rsp_valid_i) begin
      slot_vld_q <= 1'b1;
    end else if (split) begin
      slot_vld_q <= 1'b0;
      part_vld_q <= 1'b1;
      off_q      <= 1'b0;
    end else if (fire) begin
      if (part_vld_q) begin
        part_vld_q <= 1'b0; // lower parcel used, upper one next
        off_q      <= 1'b1;
      end else if (!off_q && is_c) begin
        off_q <= 1'b1;
      end else begin
        slot_vld_q <= 1'b0; // word used up
        off_q      <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rsp_valid_i && !redirect_i.valid) begin
      slot_q <= rsp_i;
    end
    if (split) begin
      part_q <= slot_q;
    end
  end

  // fetch only asks for a word when the slot is empty
  rsp_into_free_slot : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_i |-> !slot_vld_q
  );

endmodule

//--- hw/ifu_fetch.sv
`timescale 1ns/1ns

module ifu_fetch (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       req_i,
  input  ifu_pkg::redirect_t         redirect_i,
  input  logic                       slot_free_i,
  output logic                       instr_req_o,
  output logic [ifu_pkg::addr_w-1:0] instr_addr_o,
  input  logic                       instr_gnt_i,
  input  logic                       instr_rvalid_i,
  input  logic [ifu_pkg::addr_w-1:0] instr_rdata_i,
  input  logic                       instr_bus_err_i,
  output logic                       rsp_valid_o,
  output ifu_pkg::fetch_rsp_t        rsp_o,
  output logic                       busy_o
);

  logic                       req_q;     // request up, waiting for gnt
  logic                       out_q;     // granted, waiting for rvalid
  logic                       discard_q; // in-flight word belongs to old stream
  logic [ifu_pkg::addr_w-1:0] addr_q;    // address on the bus
  logic [ifu_pkg::addr_w-1:0] next_q;    // word for the next request
  logic [ifu_pkg::addr_w-1:0] target_word;
  logic [ifu_pkg::addr_w-1:0] fetch_addr;
  logic                       start;

  assign target_word = {redirect_i.target[ifu_pkg::addr_w-1:2], 2'b00};

  // one request in flight at most, and only into an empty slot
  // a redirect empties the aligner on the same edge
  assign start      = req_i & ~req_q & ~out_q & (slot_free_i | redirect_i.valid);
  assign fetch_addr = redirect_i.valid ? target_word : next_q;

  //////////////////////////////////////////////////////////////////////
  // bus handshake state
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q     <= 1'b0;
      out_q     <= 1'b0;
      discard_q <= 1'b0;
    end else begin
      if (start) begin
        req_q <= 1'b1;
      end else if (instr_gnt_i) begin
        req_q <= 1'b0; // held until here
      end

      if (req_q && instr_gnt_i) begin
        out_q <= 1'b1;
      end else if (instr_rvalid_i) begin
        out_q <= 1'b0;
      end

      // drop the response of anything requested before the redirect
      discard_q <= (discard_q & ~instr_rvalid_i) |
                   (redirect_i.valid & (req_q | (out_q & ~instr_rvalid_i)));
    end
  end

  // addresses only matter once a redirect has loaded them
  always_ff @(posedge clk_i) begin
    if (start) begin
      addr_q <= fetch_addr;
      next_q <= fetch_addr + ifu_pkg::fetch_step;
    end else if (redirect_i.valid) begin
      next_q <= target_word; // picked up once the old word is back
    end
  end

  //////////////////////////////////////////////////////////////////////
  // outputs
  //////////////////////////////////////////////////////////////////////

  assign instr_req_o  = req_q;
  assign instr_addr_o = addr_q;

  assign rsp_valid_o    = instr_rvalid_i & ~discard_q & ~redirect_i.valid;
  assign rsp_o.data     = instr_rdata_i;
  assign rsp_o.addr     = addr_q; // stable until the next start
  assign rsp_o.err      = instr_bus_err_i;

  assign busy_o = req_q | out_q;

  rvalid_only_outstanding : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    instr_rvalid_i |-> out_q
  );

  addr_held_until_gnt : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o)
  );

endmodule

//--- hw/ifu_pc_sel.sv
`timescale 1ns/1ns

module ifu_pc_sel (
  input  logic                         pc_set_i,
  input  ifu_pkg::pc_sel_e             pc_mux_i,
  input  ifu_pkg::exc_pc_sel_e         exc_pc_mux_i,
  input  ifu_pkg::exc_cause_t          exc_cause_i,
  input  logic [ifu_pkg::addr_w-1:0]   boot_addr_i,
  input  logic [ifu_pkg::addr_w-1:0]   branch_target_ex_i,
  input  logic [ifu_pkg::addr_w-1:0]   csr_mepc_i,
  input  logic [ifu_pkg::addr_w-1:0]   csr_depc_i,
  input  logic [ifu_pkg::addr_w-1:0]   csr_mtvec_i,
  input  logic                         nt_branch_mispredict_i,
  input  logic [ifu_pkg::addr_w-1:0]   nt_branch_addr_i,
  output ifu_pkg::redirect_t           redirect_o,
  output logic                         csr_mtvec_init_o
);

  logic [ifu_pkg::addr_w-1:0] mtvec_base;
  logic [ifu_pkg::addr_w-1:0] irq_offset;
  logic [ifu_pkg::addr_w-1:0] exc_pc;
  logic [ifu_pkg::addr_w-1:0] set_pc;

  //////////////////////////////////////////////////////////////////////
  // trap vector
  //////////////////////////////////////////////////////////////////////

  assign mtvec_base = {csr_mtvec_i[ifu_pkg::addr_w-1:2], 2'b00}; // drop mode bits
  assign irq_offset = {{(ifu_pkg::addr_w-7){1'b0}}, exc_cause_i.code, 2'b00}; // 4 * cause

  always_comb begin
    unique case (exc_pc_mux_i)
      ifu_pkg::exc_pc_base:     exc_pc = mtvec_base;
      ifu_pkg::exc_pc_irq:      exc_pc = mtvec_base + irq_offset;
      ifu_pkg::exc_pc_dbg_halt: exc_pc = ifu_pkg::dm_halt_addr;
      ifu_pkg::exc_pc_dbg_exc:  exc_pc = ifu_pkg::dm_exception_addr;
      default:                  exc_pc = mtvec_base;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // pc source
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (pc_mux_i)
      ifu_pkg::pc_boot: set_pc = boot_addr_i + ifu_pkg::boot_offset;
      ifu_pkg::pc_jump: set_pc = branch_target_ex_i;
      ifu_pkg::pc_exc:  set_pc = exc_pc;
      ifu_pkg::pc_mret: set_pc = csr_mepc_i;
      ifu_pkg::pc_dret: set_pc = csr_depc_i;
      default:          set_pc = boot_addr_i + ifu_pkg::boot_offset;
    endcase
  end

  // either source squashes the current stream
  assign redirect_o.valid  = pc_set_i | nt_branch_mispredict_i;
  assign redirect_o.target = pc_set_i ? {set_pc[ifu_pkg::addr_w-1:1], 1'b0} // halfword aligned
                                      : nt_branch_addr_i;

  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == ifu_pkg::pc_boot); // once per boot

  // the controller raises at most one redirect source per cycle
  mispredict_vs_pc_set : assert final (!(pc_set_i && nt_branch_mispredict_i));

endmodule

//--- hw/ifu_pkg.sv
package ifu_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths and fixed addresses
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned addr_w = 32; // address and fetch word
  localparam int unsigned half_w = 16; // one rvc parcel

  localparam logic [addr_w-1:0] dm_halt_addr      = 32'h1A11_0800; // debug rom entry
  localparam logic [addr_w-1:0] dm_exception_addr = 32'h1A11_0808;
  localparam logic [addr_w-1:0] boot_offset       = 32'h0000_0080; // first fetch past boot base
  localparam logic [addr_w-1:0] fetch_step        = 32'h0000_0004; // one bus word

  //////////////////////////////////////////////////////////////////////
  // selectors
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    pc_boot = 3'd0,
    pc_jump = 3'd1,
    pc_exc  = 3'd2, // exception or irq entry
    pc_mret = 3'd3,
    pc_dret = 3'd4
  } pc_sel_e;

  typedef enum logic [1:0] {
    exc_pc_base     = 2'd0, // mtvec, direct mode
    exc_pc_irq      = 2'd1, // mtvec, vectored
    exc_pc_dbg_halt = 2'd2,
    exc_pc_dbg_exc  = 2'd3
  } exc_pc_sel_e;

  typedef struct packed {
    logic       irq;  // interrupt, not a sync exception
    logic [4:0] code;
  } exc_cause_t;

  //////////////////////////////////////////////////////////////////////
  // stage payloads
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic              valid;  // single cycle strobe
    logic [addr_w-1:0] target;
  } redirect_t;

  typedef struct packed {
    logic [half_w-1:0] hi;
    logic [half_w-1:0] lo;
  } half_pair_t;

  // a bus word is either one rv32 instr or two parcels
  typedef union packed {
    logic [addr_w-1:0] word;
    half_pair_t        half;
  } instr_word_u;

  typedef struct packed {
    instr_word_u       data;
    logic [addr_w-1:0] addr; // word aligned
    logic              err;  // bus error on this word
  } fetch_rsp_t;

  typedef struct packed {
    logic [addr_w-1:0] instr;           // rv32 word, or rvc zero extended
    logic [half_w-1:0] instr_c;         // first parcel, for mtval
    logic              is_compressed;
    logic              illegal_c;
    logic              fetch_err;
    logic              fetch_err_plus2; // error only in second half
    logic [addr_w-1:0] pc;
  } if_instr_t;

endpackage
